//--- rtl/eeprom_macros.svh
`ifndef EEPROM_MACROS_SVH
`define EEPROM_MACROS_SVH

// pending request slots, power of two
`define EE_QUEUE_DEPTH 4

// CLK cycles per quarter of one scl period
`define EE_QUARTER_CYCLES 2

// upper nibble of every control byte
`define EE_DEVICE_CODE 4'b1010

// one bus bit in CLK cycles
`define EE_BIT_CYCLES (4 * `EE_QUARTER_CYCLES)

`endif

//--- rtl/eeprom_pkg.sv
package eeprom_pkg;

    // one host request as it sits in the queue
    typedef struct packed {
        logic        wr;    // 1 = write, 0 = read
        logic [10:0] addr;  // block in [10:8]
        logic [7:0]  data;  // write data, ignored on reads
    } eeprom_req_t;

    // control byte fields, MSB first on the wire
    typedef struct packed {
        logic [3:0] dev;
        logic [2:0] block;
        logic       rd;
    } ee_ctrl_t;

    // serial byte, built as control, shifted as raw
    typedef union packed {
        ee_ctrl_t   ctrl;
        logic [7:0] raw;
    } ee_byte_u;

endpackage

//--- rtl/eeprom_req_if.sv
`timescale 1ns/10ps

interface eeprom_req_if import eeprom_pkg::*; ();

    logic        push;  // one-cycle strobe
    logic        full;
    logic        pop;   // one-cycle strobe
    logic        empty;
    eeprom_req_t head;  // oldest entry, valid while !empty
    eeprom_req_t tail;  // entry being pushed

    modport producer (output push, output tail, input full);
    modport fifo_in  (input push, input tail, output full);
    modport fifo_out (input pop, output empty, output head);
    modport consumer (output pop, input empty, input head);

endinterface

//--- rtl/host_req_capture.sv
`timescale 1ns/10ps

module host_req_capture import eeprom_pkg::*;
(
    input  logic          CLK,
    input  logic          RESET,
    input  logic          wr,
    input  logic          rd,
    input  logic [10:0]   addr,
    input  logic [7:0]    wr_data,
    output logic          overflow,
    eeprom_req_if.producer req
);

    logic        pend_q;
    eeprom_req_t req_q;

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            pend_q   <= 1'b0;
            overflow <= 1'b0;
        end
        else
        begin
            pend_q <= wr | rd;
            if (pend_q && req.full)
            begin
                overflow <= 1'b1; // sticky until reset
            end
        end
    end

    // write wins when both strobes are high
    always_ff @(posedge CLK)
    begin
        if (wr || rd)
        begin
            req_q.wr   <= wr;
            req_q.addr <= addr;
            req_q.data <= wr_data;
        end
    end

    assign req.push = pend_q & ~req.full; // dropped when full
    assign req.tail = req_q;

endmodule

//--- rtl/req_queue.sv
`timescale 1ns/10ps
`include "eeprom_macros.svh"

module req_queue import eeprom_pkg::*;
(
    input  logic          CLK,
    input  logic          RESET,
    eeprom_req_if.fifo_in  wr_side,
    eeprom_req_if.fifo_out rd_side
);

    localparam int DEPTH = `EE_QUEUE_DEPTH;
    localparam int AW    = $clog2(DEPTH);
    localparam logic [AW:0] FULL_CNT = (AW + 1)'(DEPTH);

    eeprom_req_t   mem [DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [AW:0]   count;

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (wr_side.push)
                wr_ptr <= wr_ptr + 1'b1; // wraps at depth
            if (rd_side.pop)
                rd_ptr <= rd_ptr + 1'b1;
            case ({wr_side.push, rd_side.pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge CLK)
    begin
        if (wr_side.push)
            mem[wr_ptr] <= wr_side.tail;
    end

    assign wr_side.full  = (count == FULL_CNT);
    assign rd_side.empty = (count == '0);
    assign rd_side.head  = mem[rd_ptr]; // no read latency

    a_no_push_full: assert property (@(posedge CLK) disable iff (RESET)
        wr_side.push |-> !wr_side.full);
    a_no_pop_empty: assert property (@(posedge CLK) disable iff (RESET)
        rd_side.pop |-> !rd_side.empty);
    a_count_bound: assert property (@(posedge CLK) disable iff (RESET)
        count <= FULL_CNT);

endmodule

//--- rtl/eeprom_serial_ctrl.sv
`timescale 1ns/10ps
`include "eeprom_macros.svh"

module eeprom_serial_ctrl import eeprom_pkg::*;
(
    input  logic          CLK,
    input  logic          RESET,
    input  logic          sda_in,
    output logic          scl,
    output logic          sda_low,
    output logic          done,
    output logic          rd_valid,
    output logic [7:0]    rd_data,
    output logic          nack,
    eeprom_req_if.consumer req
);

    localparam int Q  = `EE_QUARTER_CYCLES;
    localparam int QW = (Q > 1) ? $clog2(Q) : 1;

    localparam logic [3:0] ST_IDLE   = 4'd0;
    localparam logic [3:0] ST_START  = 4'd1;
    localparam logic [3:0] ST_CTRL_W = 4'd2;
    localparam logic [3:0] ST_ADDR   = 4'd3;
    localparam logic [3:0] ST_DATA_W = 4'd4;
    localparam logic [3:0] ST_RSTART = 4'd5;
    localparam logic [3:0] ST_CTRL_R = 4'd6;
    localparam logic [3:0] ST_DATA_R = 4'd7;
    localparam logic [3:0] ST_MACK   = 4'd8;
    localparam logic [3:0] ST_STOP   = 4'd9;

    logic [3:0]    state;
    logic [QW-1:0] qcnt;
    logic [1:0]    phase;     // quarter within a bus bit
    logic [3:0]    bcnt;      // bit slot where 8 is the ack
    logic          nack_q;
    logic          smp;       // sda sampled mid high
    ee_byte_u      sh;
    eeprom_req_t   cur;

    logic q_tick;
    logic smp_pt;
    logic slot_end;
    logic ack_slot;
    logic send_st;

    assign q_tick   = (qcnt == QW'(Q - 1));
    assign smp_pt   = q_tick && (phase == 2'd1);
    assign slot_end = q_tick && (phase == 2'd3);
    assign ack_slot = (bcnt == 4'd8);
    assign send_st  = (state == ST_CTRL_W) || (state == ST_ADDR) ||
                      (state == ST_DATA_W) || (state == ST_CTRL_R);

    assign req.pop = (state == ST_IDLE) && !req.empty;
    assign rd_data = sh.raw;

    always_ff @(posedge CLK)
    begin
        if (RESET || state == ST_IDLE)
        begin
            qcnt  <= '0;
            phase <= 2'd0;
        end
        else if (q_tick)
        begin
            qcnt  <= '0;
            phase <= phase + 2'd1;
        end
        else
        begin
            qcnt <= qcnt + 1'b1;
        end
    end

    // scl high in the middle two quarters and from the second quarter of stop
    always_comb
    begin
        case (state)
            ST_IDLE: scl = 1'b1;
            ST_STOP: scl = (phase != 2'd0);
            default: scl = (phase == 2'd1) || (phase == 2'd2);
        endcase
    end

    always_comb
    begin
        if (state == ST_START || state == ST_RSTART)
            sda_low = phase[1];            // falls while scl high
        else if (state == ST_STOP)
            sda_low = !phase[1];           // rises while scl high
        else if (send_st)
            sda_low = !ack_slot && !sh.raw[7];
        else
            sda_low = 1'b0;
    end

    always_ff @(posedge CLK)
    begin
        if (req.pop)
            cur <= req.head;
        if (smp_pt)
        begin
            smp <= sda_in;
            if (state == ST_DATA_R)
                sh.raw <= {sh.raw[6:0], sda_in};
        end
        if (slot_end)
        begin
            case (state)
                ST_START, ST_RSTART:
                begin
                    sh.ctrl.dev   <= `EE_DEVICE_CODE;
                    sh.ctrl.block <= cur.addr[10:8];
                    sh.ctrl.rd    <= (state == ST_RSTART);
                end
                ST_CTRL_W:
                    sh.raw <= ack_slot ? cur.addr[7:0] : {sh.raw[6:0], 1'b0};
                ST_ADDR:
                    sh.raw <= ack_slot ? cur.data : {sh.raw[6:0], 1'b0};
                ST_DATA_W, ST_CTRL_R:
                    if (!ack_slot)
                        sh.raw <= {sh.raw[6:0], 1'b0};
                default: ;
            endcase
        end
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state    <= ST_IDLE;
            bcnt     <= 4'd0;
            nack_q   <= 1'b0;
            done     <= 1'b0;
            rd_valid <= 1'b0;
            nack     <= 1'b0;
        end
        else
        begin
            done     <= 1'b0;
            rd_valid <= 1'b0;
            nack     <= 1'b0;
            case (state)
                ST_IDLE:
                    if (!req.empty)
                    begin
                        state  <= ST_START;
                        nack_q <= 1'b0;
                    end
                ST_START, ST_RSTART:
                    if (slot_end)
                    begin
                        state <= (state == ST_START) ? ST_CTRL_W : ST_CTRL_R;
                        bcnt  <= 4'd0;
                    end
                ST_CTRL_W, ST_ADDR, ST_DATA_W, ST_CTRL_R:
                    if (slot_end)
                    begin
                        bcnt <= ack_slot ? 4'd0 : bcnt + 4'd1;
                        if (ack_slot && smp)
                        begin
                            nack_q <= 1'b1; // no device ack so abort
                            state  <= ST_STOP;
                        end
                        else if (ack_slot)
                        begin
                            case (state)
                                ST_CTRL_W: state <= ST_ADDR;
                                ST_ADDR:   state <= cur.wr ? ST_DATA_W : ST_RSTART;
                                ST_DATA_W: state <= ST_STOP;
                                default:   state <= ST_DATA_R;
                            endcase
                        end
                    end
                ST_DATA_R:
                    if (slot_end)
                    begin
                        bcnt <= bcnt + 4'd1;
                        if (bcnt == 4'd7)
                            state <= ST_MACK;
                    end
                ST_MACK:
                    if (slot_end)
                        state <= ST_STOP;    // sda left released
                ST_STOP:
                    if (slot_end)
                    begin
                        state    <= ST_IDLE;
                        done     <= 1'b1;
                        nack     <= nack_q;
                        rd_valid <= !cur.wr && !nack_q;
                    end
                default:
                    state <= ST_IDLE;
            endcase
        end
    end

    // data only moves under scl low except in start and stop
    a_sda_stable: assert property (@(posedge CLK) disable iff (RESET)
        (scl && $past(scl) && (sda_low != $past(sda_low)))
            |-> (state == ST_START || state == ST_RSTART || state == ST_STOP));

    a_done_pulse: assert property (@(posedge CLK) disable iff (RESET)
        done |=> !done);

endmodule

//--- rtl/eeprom_subsys.sv
`timescale 1ns/10ps

module eeprom_subsys
(
    input  logic        CLK,
    input  logic        RESET,
    input  logic        wr,
    input  logic        rd,
    input  logic [10:0] addr,
    input  logic [7:0]  wr_data,
    input  logic        sda_in,
    output logic        scl,
    output logic        sda_low,
    output logic        done,
    output logic        rd_valid,
    output logic [7:0]  rd_data,
    output logic        nack,
    output logic        overflow
);

    eeprom_req_if cap_q ();   // capture to queue
    eeprom_req_if q_ctrl ();  // queue to controller

    host_req_capture u_capture (
        .CLK      (CLK),
        .RESET    (RESET),
        .wr       (wr),
        .rd       (rd),
        .addr     (addr),
        .wr_data  (wr_data),
        .overflow (overflow),
        .req      (cap_q.producer)
    );

    req_queue u_queue (
        .CLK     (CLK),
        .RESET   (RESET),
        .wr_side (cap_q.fifo_in),
        .rd_side (q_ctrl.fifo_out)
    );

    eeprom_serial_ctrl u_ctrl (
        .CLK      (CLK),
        .RESET    (RESET),
        .sda_in   (sda_in),
        .scl      (scl),
        .sda_low  (sda_low),
        .done     (done),
        .rd_valid (rd_valid),
        .rd_data  (rd_data),
        .nack     (nack),
        .req      (q_ctrl.consumer)
    );

endmodule

//--- tests/eeprom_model.sv
`timescale 1ns/10ps

module eeprom_model
(
    input  logic CLK,
    input  logic RESET,
    input  logic scl,
    input  logic sda,       // resolved bus level
    output logic pull_low   // model side of the open drain
);

    localparam logic [1:0] M_IDLE = 2'd0;
    localparam logic [1:0] M_RX   = 2'd1;
    localparam logic [1:0] M_ACK  = 2'd2;
    localparam logic [1:0] M_TX   = 2'd3;

    logic [7:0] mem [2048];
    logic       scl_d;
    logic       sda_d;
    logic [1:0] st;
    logic [3:0] bitn;
    logic [1:0] byte_idx;   // 0 control, 1 address, 2 data
    logic [7:0] shreg;
    logic [7:0] txreg;
    logic [2:0] blk;
    logic [7:0] word;
    logic       rd_mode;

    initial
    begin
        for (int i = 0; i < 2048; i++)
            mem[i] = 8'hff; // erased
    end

    // bus edges seen one CLK late, scl quarters are wider than that
    always @(posedge CLK)
    begin
        scl_d <= scl;
        sda_d <= sda;
        if (RESET)
        begin
            st       <= M_IDLE;
            pull_low <= 1'b0;
            bitn     <= 4'd0;
            byte_idx <= 2'd0;
            rd_mode  <= 1'b0;
        end
        else if (scl_d && scl && sda_d && !sda)
        begin
            st       <= M_RX; // start or repeated start
            bitn     <= 4'd0;
            byte_idx <= 2'd0;
            pull_low <= 1'b0;
        end
        else if (scl_d && scl && !sda_d && sda)
        begin
            st       <= M_IDLE; // stop
            pull_low <= 1'b0;
        end
        else if (!scl_d && scl)
        begin
            if (st == M_RX)
            begin
                shreg <= {shreg[6:0], sda};
                bitn  <= bitn + 4'd1;
            end
            else if (st == M_TX)
                bitn <= bitn + 4'd1;
        end
        else if (scl_d && !scl)
        begin
            case (st)
                M_RX:
                    if (bitn == 4'd8)
                    begin
                        byte_idx <= byte_idx + 2'd1;
                        if (byte_idx == 2'd0)
                        begin
                            // block 7 never answers
                            if (shreg[7:4] == 4'b1010 && shreg[3:1] != 3'd7)
                            begin
                                blk      <= shreg[3:1];
                                rd_mode  <= shreg[0];
                                pull_low <= 1'b1;
                                st       <= M_ACK;
                            end
                            else
                                st <= M_IDLE;
                        end
                        else
                        begin
                            if (byte_idx == 2'd1)
                                word <= shreg;
                            else
                                mem[{blk, word}] <= shreg;
                            pull_low <= 1'b1;
                            st       <= M_ACK;
                        end
                    end
                M_ACK:
                begin
                    bitn <= 4'd0;
                    if (rd_mode)
                    begin
                        txreg    <= mem[{blk, word}];
                        pull_low <= !mem[{blk, word}][7];
                        st       <= M_TX;
                    end
                    else
                    begin
                        pull_low <= 1'b0;
                        st       <= M_RX;
                    end
                end
                M_TX:
                    if (bitn == 4'd8)
                    begin
                        pull_low <= 1'b0; // master ack slot left to the master
                        st       <= M_IDLE;
                    end
                    else
                    begin
                        pull_low <= !txreg[6];
                        txreg    <= {txreg[6:0], 1'b1};
                    end
                default: ;
            endcase
        end
    end

endmodule

//--- tests/tb_eeprom_subsys.sv
`timescale 1ns/10ps
`include "eeprom_macros.svh"

module tb_eeprom_subsys;

    localparam int DEPTH      = `EE_QUEUE_DEPTH;
    localparam int N_RAND     = 40;
    localparam int TOTAL_REQ  = N_RAND + 4 + (DEPTH + 1) + (DEPTH + 3) + 2;
    localparam int REQ_CYCLES = 40 * `EE_BIT_CYCLES; // longer than a full read
    localparam int WATCHDOG_CYCLES = TOTAL_REQ * REQ_CYCLES + 3 * REQ_CYCLES + 200;

    logic        CLK;
    logic        RESET;
    logic        wr;
    logic        rd;
    logic [10:0] addr;
    logic [7:0]  wr_data;
    logic        scl;
    logic        sda_low;
    logic        done;
    logic        rd_valid;
    logic [7:0]  rd_data;
    logic        nack;
    logic        overflow;
    logic        sda_bus;
    logic        mdl_low;

    logic [7:0]  ref_mem [2048];
    logic [9:0]  exp_q [$];  // {nack, rd_valid, data} in issue order
    logic [9:0]  exp_e;
    logic [31:0] lfsr;
    logic [10:0] dropped [2];
    int          issued;
    int          done_count;
    int          errors;

    always #5 CLK = ~CLK;

    assign sda_bus = !(sda_low || mdl_low); // wired and

    eeprom_subsys u_dut (
        .CLK      (CLK),
        .RESET    (RESET),
        .wr       (wr),
        .rd       (rd),
        .addr     (addr),
        .wr_data  (wr_data),
        .sda_in   (sda_bus),
        .scl      (scl),
        .sda_low  (sda_low),
        .done     (done),
        .rd_valid (rd_valid),
        .rd_data  (rd_data),
        .nack     (nack),
        .overflow (overflow)
    );

    eeprom_model u_model (
        .CLK      (CLK),
        .RESET    (RESET),
        .scl      (scl),
        .sda      (sda_bus),
        .pull_low (mdl_low)
    );

    task automatic fail_run(input string why);
        errors++;
        $display("%s", why);
        $display("Errors found");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic check_eq(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp)
        begin
            $display("Mismatch at %0t: %s expected %0h got %0h", $time, name, exp, act);
            fail_run("compare failed");
        end
    endtask

    // taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic rand_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            lfsr = lfsr_step(lfsr);
            v    = {v[30:0], lfsr[0]};
        end
    endtask

    // blocks 0 to 6 with 16 addresses each
    task automatic pick_req(output logic is_wr, output logic [10:0] a, output logic [7:0] d);
        logic [31:0] r;
        logic [2:0]  blk;
        rand_bits(1, r);
        is_wr = r[0];
        blk   = 3'd7;
        while (blk == 3'd7)
        begin
            rand_bits(3, r);
            blk = r[2:0];
        end
        rand_bits(4, r);
        a = {blk, r[3:0], ~r[3:0]};
        rand_bits(8, r);
        d = r[7:0];
    endtask

    task automatic drive_req(input logic is_wr, input logic [10:0] a, input logic [7:0] d);
        @(posedge CLK);
        #1;
        wr      = is_wr;
        rd      = !is_wr;
        addr    = a;
        wr_data = d;
    endtask

    task automatic release_bus();
        @(posedge CLK);
        #1;
        wr = 1'b0;
        rd = 1'b0;
    endtask

    task automatic expect_req(input logic is_wr, input logic [10:0] a, input logic [7:0] d);
        issued++;
        if (a[10:8] == 3'd7)
            exp_q.push_back({2'b10, 8'h00});
        else if (is_wr)
        begin
            ref_mem[a] = d;
            exp_q.push_back({2'b00, 8'h00});
        end
        else
            exp_q.push_back({2'b01, ref_mem[a]});
    endtask

    task automatic wait_all_done();
        while (done_count != issued)
            @(posedge CLK);
        repeat (2) @(posedge CLK);
    endtask

    task automatic send_one(input logic is_wr, input logic [10:0] a, input logic [7:0] d);
        drive_req(is_wr, a, d);
        expect_req(is_wr, a, d);
        release_bus();
        wait_all_done();
    endtask

    // registered results are stable at negedge
    always @(negedge CLK)
    begin
        if (!RESET && done)
        begin
            if (exp_q.size() == 0)
                fail_run("done pulse arrived with no request outstanding");
            else
            begin
                exp_e = exp_q.pop_front();
                check_eq("nack", exp_e[9], nack);
                check_eq("rd_valid", exp_e[8], rd_valid);
                if (exp_e[8])
                    check_eq("rd_data", exp_e[7:0], rd_data);
                done_count++;
            end
        end
        else if (!RESET)
        begin
            check_eq("nack", 1'b0, nack);
            check_eq("rd_valid", 1'b0, rd_valid);
        end
    end

    initial
    begin
        repeat (WATCHDOG_CYCLES) @(posedge CLK);
        fail_run("watchdog expired, the run hung before all transactions finished");
    end

    initial
    begin : main_seq
        logic        is_wr;
        logic [10:0] a;
        logic [7:0]  d;
        CLK     = 1'b0;
        RESET   = 1'b1;
        wr      = 1'b0;
        rd      = 1'b0;
        addr    = '0;
        wr_data = '0;
        lfsr    = 32'hf199;
        for (int i = 0; i < 2048; i++)
            ref_mem[i] = 8'hff;
        repeat (8) @(posedge CLK);
        #1;
        RESET = 1'b0;

        @(negedge CLK);
        check_eq("scl", 1'b1, scl);
        check_eq("sda_low", 1'b0, sda_low);
        check_eq("done", 1'b0, done);
        check_eq("rd_valid", 1'b0, rd_valid);
        check_eq("nack", 1'b0, nack);
        check_eq("overflow", 1'b0, overflow);

        for (int i = 0; i < N_RAND; i++)
        begin
            pick_req(is_wr, a, d);
            send_one(is_wr, a, d);
        end

        // block 7 write and read both abort
        for (int i = 0; i < 2; i++)
        begin
            pick_req(is_wr, a, d);
            a[10:8] = 3'd7;
            send_one(1'b1, a, d);
            send_one(1'b0, a, 8'h00);
        end

        for (int i = 0; i < DEPTH + 1; i++)
        begin
            pick_req(is_wr, a, d);
            drive_req(is_wr, a, d);
            expect_req(is_wr, a, d);
        end
        release_bus();
        wait_all_done();
        @(negedge CLK);
        check_eq("overflow", 1'b0, overflow);

        // last two strobes land on a full queue
        for (int i = 0; i < DEPTH + 3; i++)
        begin
            pick_req(is_wr, a, d);
            if (i >= DEPTH + 1)
            begin
                dropped[i - DEPTH - 1] = a;
                drive_req(1'b1, a, ~ref_mem[a]);
            end
            else
            begin
                drive_req(is_wr, a, d);
                expect_req(is_wr, a, d);
            end
        end
        release_bus();
        wait_all_done();
        repeat (2 * REQ_CYCLES) @(posedge CLK); // room for stray done pulses
        @(negedge CLK);
        check_eq("overflow", 1'b1, overflow);
        send_one(1'b0, dropped[0], 8'h00);
        send_one(1'b0, dropped[1], 8'h00);

        if (errors == 0)
            $display("No errors");
        else
            $display("Errors found");
        $finish;
    end

endmodule

//--- vlog.f
+incdir+rtl
rtl/eeprom_pkg.sv
rtl/eeprom_req_if.sv
rtl/host_req_capture.sv
rtl/req_queue.sv
rtl/eeprom_serial_ctrl.sv
rtl/eeprom_subsys.sv
tests/eeprom_model.sv
tests/tb_eeprom_subsys.sv

//--- Makefile
VERILATOR  = verilator
VFLAGS     = --binary --timing --assert -Wno-fatal -j 0
LINT_FLAGS = --lint-only --timing -Wall
TOP        = tb_eeprom_subsys
FILELIST   = vlog.f
OBJ_DIR    = obj_dir
LOG        = sim.log
PASS_MSG   = No errors

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
